//--- design/md_params.svh
/* Console bus core parameters
   Address map widths, register widths and reset values */

`ifndef MD_PARAMS_SVH
`define MD_PARAMS_SVH

// Main bus word address, byte address bits 23:1
`define MD_MAIN_AW 23

// 64 KB work RAM as 32K words
`define MD_WRAM_AW 15

// 8 KB sound RAM, byte addressed
`define MD_SRAM_AW 13

// Sound bus byte address, 0000-7FFF
`define MD_ZBUS_AW 15

// Sound CPU bank register, main address bits 23:15
`define MD_BAR_W 9

// Open bus word seen before any host read completes
`define MD_OPEN_BUS_INIT 16'h4E71

// Byte returned when nothing on the sound bus answers
`define MD_NO_DATA_BYTE 8'hFF

`endif

//--- design/md_pkg.sv
/* Console bus core types
   Request structs for the host port, the sound CPU port and the sound bus */

`include "md_params.svh"

package md_pkg;

	typedef logic [15:0] word_t;
	typedef logic [7:0]  byte_t;

	// Host CPU access, 68000 style with byte lanes
	typedef struct packed {
		logic [`MD_MAIN_AW-1:0] addr;
		word_t                  wdata;
		logic                   rnw;
		logic                   uds;
		logic                   lds;
	} main_req_t;

	// Sound CPU access, Z80 style byte bus
	typedef struct packed {
		logic [15:0] addr;
		byte_t       wdata;
		logic        rnw;
	} sub_req_t;

	// One access on the sound bus
	typedef struct packed {
		logic [`MD_ZBUS_AW-1:0] addr;
		byte_t                  wdata;
		logic                   we;
	} zbus_req_t;

endpackage

//--- design/sync_ram.sv
/* Single-port byte RAM
   Write and read on the clock edge, read data one cycle after the address */

`timescale 1ns/100ps

module sync_ram #(
	parameter int AW = 13
) (
	input  logic          MCLK,
	input  logic [AW-1:0] addr,
	input  md_pkg::byte_t wdata,
	input  logic          we,
	output md_pkg::byte_t rdata
);

	md_pkg::byte_t mem [0:(1 << AW) - 1];

	// Old contents come out on a write to the same address
	always_ff @(posedge MCLK) begin
		if (we) begin
			mem[addr] <= wdata;
		end
		rdata <= mem[addr];
	end

endmodule

//--- design/main_bus_arbiter.sv
/* Main bus arbiter
   Serves host and sound CPU requests over ROM, work RAM, control and sound window */

`timescale 1ns/100ps
`include "md_params.svh"

module main_bus_arbiter (
	input  logic                   MCLK,
	input  logic                   reset,

	input  md_pkg::main_req_t      main_req,
	input  logic                   main_valid,
	output md_pkg::word_t          main_rdata,
	output logic                   main_done,

	input  md_pkg::sub_req_t       sub_req,
	input  logic                   sub_valid,
	output md_pkg::byte_t          sub_rdata,
	output logic                   sub_done,

	input  logic [`MD_BAR_W-1:0]   bar,

	output logic [`MD_WRAM_AW-1:0] wram_addr,
	output md_pkg::word_t          wram_wdata,
	output logic                   wram_we_hi,
	output logic                   wram_we_lo,
	input  md_pkg::word_t          wram_rdata,

	output md_pkg::zbus_req_t      zbus_req,
	output logic                   zbus_valid,
	input  md_pkg::byte_t          zbus_rdata,
	input  logic                   zbus_done,

	output logic                   busreq,
	output logic                   z80_reset_n,

	output logic [`MD_MAIN_AW-1:0] rom_addr,
	output logic                   rom_req,
	input  logic                   rom_ack,
	input  md_pkg::word_t          rom_data,
	output logic                   rom_we,
	output md_pkg::word_t          rom_wdata,
	output logic [1:0]             rom_be
);

	typedef enum logic [2:0] {
		st_idle,
		st_select,
		st_capture,
		st_rom,
		st_zbus,
		st_finish
	} state_t;

	state_t            state;
	logic              src_sub;
	logic              sub_a0;
	md_pkg::main_req_t mreq;
	md_pkg::word_t     data;
	md_pkg::word_t     open_bus;

	logic              is_rom;
	logic              is_zbus;
	logic              is_ctrl;
	logic              is_wram;
	logic              ctrl_busreq;
	logic              ctrl_reset;
	logic              ctrl_bit;
	md_pkg::word_t     ctrl_do;
	logic              host_read;

	// -------------------------------------------------------------------------
	// Address decode of the latched request
	// -------------------------------------------------------------------------
	assign is_rom  = mreq.addr[22:19] < 4'hA;
	assign is_zbus = mreq.addr[22:15] == 8'hA0;
	assign is_ctrl = (mreq.addr[22:11] == 12'hA11) && (mreq.addr[6:0] == 7'd0);
	assign is_wram = &mreq.addr[22:20];

	// A11100 bus request, A11200 sound CPU reset
	assign ctrl_busreq = is_ctrl && (mreq.addr[10:7] == 4'h1);
	assign ctrl_reset  = is_ctrl && (mreq.addr[10:7] == 4'h2);

	// Grant follows the request at once, so not-granted is ~busreq
	assign ctrl_bit = ctrl_busreq ? ~busreq : (ctrl_reset ? ~z80_reset_n : open_bus[8]);
	assign ctrl_do  = {open_bus[15:9], ctrl_bit, open_bus[7:0]};

	assign host_read = !src_sub && mreq.rnw;

	// Work RAM lanes strobe during the select cycle
	assign wram_addr  = mreq.addr[`MD_WRAM_AW-1:0];
	assign wram_wdata = mreq.wdata;
	assign wram_we_hi = (state == st_select) && is_wram && !mreq.rnw && mreq.uds;
	assign wram_we_lo = (state == st_select) && is_wram && !mreq.rnw && mreq.lds;

	assign rom_addr  = mreq.addr;
	assign rom_wdata = mreq.wdata;
	assign rom_be    = {mreq.uds, mreq.lds};

	// Sound window picks the upper byte when the upper lane is on
	assign zbus_req.addr  = {mreq.addr[13:0], ~mreq.uds};
	assign zbus_req.wdata = mreq.uds ? mreq.wdata[15:8] : mreq.wdata[7:0];
	assign zbus_req.we    = !mreq.rnw;

	// -------------------------------------------------------------------------
	// Bus FSM, control registers and open bus
	// -------------------------------------------------------------------------
	always_ff @(posedge MCLK) begin
		if (reset) begin
			state       <= st_idle;
			src_sub     <= 1'b0;
			main_done   <= 1'b0;
			sub_done    <= 1'b0;
			zbus_valid  <= 1'b0;
			rom_req     <= 1'b0;
			rom_we      <= 1'b0;
			busreq      <= 1'b0;
			z80_reset_n <= 1'b0;
			open_bus    <= `MD_OPEN_BUS_INIT;
		end else begin
			case (state)
				st_idle: begin
					// Host port wins a tie
					if (main_valid) begin
						src_sub <= 1'b0;
						state   <= st_select;
					end else if (sub_valid) begin
						src_sub <= 1'b1;
						state   <= st_select;
					end
				end
				st_select: begin
					if (is_rom) begin
						rom_req <= ~rom_ack;
						rom_we  <= !mreq.rnw;
						state   <= st_rom;
					end else if (is_zbus) begin
						zbus_valid <= 1'b1;
						state      <= st_zbus;
					end else begin
						if (is_ctrl && !mreq.rnw && mreq.uds) begin
							if (ctrl_busreq) begin
								busreq <= mreq.wdata[8];
							end
							if (ctrl_reset) begin
								z80_reset_n <= mreq.wdata[8];
							end
						end
						state <= st_capture;
					end
				end
				st_capture: begin
					if (is_wram && host_read) begin
						open_bus <= wram_rdata;
					end
					state <= st_finish;
				end
				st_rom: begin
					// Toggle matched, ROM access complete
					if (rom_req == rom_ack) begin
						if (host_read) begin
							open_bus <= rom_data;
						end
						state <= st_finish;
					end
				end
				st_zbus: begin
					if (zbus_done) begin
						zbus_valid <= 1'b0;
						state      <= st_finish;
					end
				end
				st_finish: begin
					// Hold done until the source drops its request
					if (!src_sub) begin
						if (!main_done) begin
							main_done <= 1'b1;
						end else if (!main_valid) begin
							main_done <= 1'b0;
							state     <= st_idle;
						end
					end else begin
						if (!sub_done) begin
							sub_done <= 1'b1;
						end else if (!sub_valid) begin
							sub_done <= 1'b0;
							state    <= st_idle;
						end
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// Request latch and read data path
	always_ff @(posedge MCLK) begin
		case (state)
			st_idle: begin
				if (main_valid) begin
					mreq <= main_req;
				end else if (sub_valid) begin
					// Upper 32 KB window placed by the bank register
					mreq.addr  <= {bar, sub_req.addr[14:1]};
					mreq.wdata <= {sub_req.wdata, sub_req.wdata};
					mreq.rnw   <= sub_req.rnw;
					mreq.uds   <= ~sub_req.addr[0];
					mreq.lds   <= sub_req.addr[0];
					sub_a0     <= sub_req.addr[0];
				end
			end
			st_capture: begin
				data <= is_wram ? wram_rdata : (is_ctrl ? ctrl_do : open_bus);
			end
			st_rom: begin
				if (rom_req == rom_ack) begin
					data <= rom_data;
				end
			end
			st_zbus: begin
				if (zbus_done) begin
					data <= {zbus_rdata, zbus_rdata};
				end
			end
			st_finish: begin
				if (!src_sub) begin
					main_rdata <= data;
				end else begin
					sub_rdata <= sub_a0 ? data[7:0] : data[15:8];
				end
			end
			default: ;
		endcase
	end

endmodule

//--- design/sound_bus_arbiter.sv
/* Sound bus arbiter
   Shares the sound RAM and bank register between the main window and the sound CPU */

`timescale 1ns/100ps
`include "md_params.svh"

module sound_bus_arbiter (
	input  logic                   MCLK,
	input  logic                   reset,

	input  md_pkg::zbus_req_t      win_req,
	input  logic                   win_valid,
	output md_pkg::byte_t          win_rdata,
	output logic                   win_done,

	input  md_pkg::sub_req_t       sub_req,
	input  logic                   sub_valid,
	output md_pkg::byte_t          sub_rdata,
	output logic                   sub_done,

	input  logic                   busreq,
	input  logic                   z80_reset_n,
	output logic [`MD_BAR_W-1:0]   bar,

	output logic [`MD_SRAM_AW-1:0] sram_addr,
	output md_pkg::byte_t          sram_wdata,
	output logic                   sram_we,
	input  md_pkg::byte_t          sram_rdata
);

	typedef enum logic [1:0] {
		st_idle,
		st_read,
		st_finish
	} state_t;

	state_t                 state;
	logic                   src_win;
	logic [`MD_ZBUS_AW-1:0] zaddr;
	md_pkg::byte_t          zwdata;
	logic                   zwe;

	logic                   bus_free;
	logic                   sram_sel;
	logic                   bank_sel;
	md_pkg::byte_t          zdi;

	// Main side owns the bus only with the sound CPU held off and out of reset
	assign bus_free = busreq && z80_reset_n;

	// 0000-3FFF RAM with 8 KB mirror, 6000-60FF bank register
	assign sram_sel = !zaddr[14];
	assign bank_sel = zaddr[14:8] == 7'h60;
	assign zdi      = sram_sel ? sram_rdata : `MD_NO_DATA_BYTE;

	assign sram_addr  = zaddr[`MD_SRAM_AW-1:0];
	assign sram_wdata = zwdata;
	assign sram_we    = (state == st_read) && zwe && sram_sel;

	// -------------------------------------------------------------------------
	// Three-state access sequence
	// -------------------------------------------------------------------------
	always_ff @(posedge MCLK) begin
		if (reset) begin
			state    <= st_idle;
			src_win  <= 1'b0;
			win_done <= 1'b0;
			sub_done <= 1'b0;
			bar      <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (win_valid) begin
						src_win <= 1'b1;
						state   <= st_read;
					end else if (sub_valid) begin
						src_win <= 1'b0;
						state   <= st_read;
					end
				end
				st_read: begin
					// Serial load, one bit per write into the MSB
					if (bank_sel && zwe) begin
						bar <= {zwdata[0], bar[`MD_BAR_W-1:1]};
					end
					state <= st_finish;
				end
				st_finish: begin
					if (src_win) begin
						if (!win_done) begin
							win_done <= 1'b1;
						end else if (!win_valid) begin
							win_done <= 1'b0;
							state    <= st_idle;
						end
					end else begin
						if (!sub_done) begin
							sub_done <= 1'b1;
						end else if (!sub_valid) begin
							sub_done <= 1'b0;
							state    <= st_idle;
						end
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// Request latch and read data
	always_ff @(posedge MCLK) begin
		case (state)
			st_idle: begin
				if (win_valid) begin
					zaddr  <= win_req.addr;
					zwdata <= win_req.wdata;
					// Window writes are dropped while the bus is not free
					zwe    <= win_req.we && bus_free;
				end else if (sub_valid) begin
					zaddr  <= sub_req.addr[`MD_ZBUS_AW-1:0];
					zwdata <= sub_req.wdata;
					zwe    <= !sub_req.rnw;
				end
			end
			st_finish: begin
				if (src_win && !win_done) begin
					win_rdata <= bus_free ? zdi : `MD_NO_DATA_BYTE;
				end else if (!src_win && !sub_done) begin
					sub_rdata <= zdi;
				end
			end
			default: ;
		endcase
	end

endmodule

//--- design/md_bus_top.sv
/* Console bus core top level
   Main and sound bus arbiters with work RAM and sound RAM */

`timescale 1ns/100ps
`include "md_params.svh"

module md_bus_top (
	input  logic                   MCLK,
	input  logic                   reset,

	input  md_pkg::main_req_t      main_req,
	input  logic                   main_valid,
	output md_pkg::word_t          main_rdata,
	output logic                   main_done,

	input  md_pkg::sub_req_t       sub_req,
	input  logic                   sub_valid,
	output md_pkg::byte_t          sub_rdata,
	output logic                   sub_done,

	output logic [`MD_MAIN_AW-1:0] rom_addr,
	output logic                   rom_req,
	input  logic                   rom_ack,
	input  md_pkg::word_t          rom_data,
	output logic                   rom_we,
	output md_pkg::word_t          rom_wdata,
	output logic [1:0]             rom_be,

	output logic                   busreq,
	output logic                   z80_reset_n
);

	logic [`MD_BAR_W-1:0]   bar;
	logic [`MD_WRAM_AW-1:0] wram_addr;
	md_pkg::word_t          wram_wdata;
	logic                   wram_we_hi;
	logic                   wram_we_lo;
	md_pkg::word_t          wram_rdata;

	md_pkg::zbus_req_t      zbus_req;
	logic                   zbus_valid;
	md_pkg::byte_t          zbus_rdata;
	logic                   zbus_done;

	logic [`MD_SRAM_AW-1:0] sram_addr;
	md_pkg::byte_t          sram_wdata;
	logic                   sram_we;
	md_pkg::byte_t          sram_rdata;

	logic                   msub_valid;
	md_pkg::byte_t          msub_rdata;
	logic                   msub_done;
	logic                   zsub_valid;
	md_pkg::byte_t          zsub_rdata;
	logic                   zsub_done;

	// Sound CPU split by address bit 15
	assign msub_valid = sub_valid && sub_req.addr[15];
	assign zsub_valid = sub_valid && !sub_req.addr[15];
	assign sub_done   = sub_req.addr[15] ? msub_done : zsub_done;
	assign sub_rdata  = sub_req.addr[15] ? msub_rdata : zsub_rdata;

	main_bus_arbiter i_main_arb (
		.MCLK        (MCLK),
		.reset       (reset),
		.main_req    (main_req),
		.main_valid  (main_valid),
		.main_rdata  (main_rdata),
		.main_done   (main_done),
		.sub_req     (sub_req),
		.sub_valid   (msub_valid),
		.sub_rdata   (msub_rdata),
		.sub_done    (msub_done),
		.bar         (bar),
		.wram_addr   (wram_addr),
		.wram_wdata  (wram_wdata),
		.wram_we_hi  (wram_we_hi),
		.wram_we_lo  (wram_we_lo),
		.wram_rdata  (wram_rdata),
		.zbus_req    (zbus_req),
		.zbus_valid  (zbus_valid),
		.zbus_rdata  (zbus_rdata),
		.zbus_done   (zbus_done),
		.busreq      (busreq),
		.z80_reset_n (z80_reset_n),
		.rom_addr    (rom_addr),
		.rom_req     (rom_req),
		.rom_ack     (rom_ack),
		.rom_data    (rom_data),
		.rom_we      (rom_we),
		.rom_wdata   (rom_wdata),
		.rom_be      (rom_be)
	);

	sound_bus_arbiter i_sound_arb (
		.MCLK        (MCLK),
		.reset       (reset),
		.win_req     (zbus_req),
		.win_valid   (zbus_valid),
		.win_rdata   (zbus_rdata),
		.win_done    (zbus_done),
		.sub_req     (sub_req),
		.sub_valid   (zsub_valid),
		.sub_rdata   (zsub_rdata),
		.sub_done    (zsub_done),
		.busreq      (busreq),
		.z80_reset_n (z80_reset_n),
		.bar         (bar),
		.sram_addr   (sram_addr),
		.sram_wdata  (sram_wdata),
		.sram_we     (sram_we),
		.sram_rdata  (sram_rdata)
	);

	// Work RAM, upper and lower byte lanes
	sync_ram #(.AW(`MD_WRAM_AW)) i_wram_hi (
		.MCLK  (MCLK),
		.addr  (wram_addr),
		.wdata (wram_wdata[15:8]),
		.we    (wram_we_hi),
		.rdata (wram_rdata[15:8])
	);

	sync_ram #(.AW(`MD_WRAM_AW)) i_wram_lo (
		.MCLK  (MCLK),
		.addr  (wram_addr),
		.wdata (wram_wdata[7:0]),
		.we    (wram_we_lo),
		.rdata (wram_rdata[7:0])
	);

	sync_ram #(.AW(`MD_SRAM_AW)) i_sram (
		.MCLK  (MCLK),
		.addr  (sram_addr),
		.wdata (sram_wdata),
		.we    (sram_we),
		.rdata (sram_rdata)
	);

endmodule

//--- tests/tb_md_bus.sv
/* Console bus core testbench
   Host and sound CPU accesses checked against reference models of RAM, ROM and registers */

`timescale 1ns/100ps
`include "md_params.svh"

module tb_md_bus;

	logic                   MCLK = 1'b0;
	logic                   reset;
	md_pkg::main_req_t      main_req;
	logic                   main_valid;
	md_pkg::word_t          main_rdata;
	logic                   main_done;
	md_pkg::sub_req_t       sub_req;
	logic                   sub_valid;
	md_pkg::byte_t          sub_rdata;
	logic                   sub_done;
	logic [`MD_MAIN_AW-1:0] rom_addr;
	logic                   rom_req;
	logic                   rom_ack;
	md_pkg::word_t          rom_data;
	logic                   rom_we;
	md_pkg::word_t          rom_wdata;
	logic [1:0]             rom_be;
	logic                   busreq;
	logic                   z80_reset_n;

	// Reference model state
	md_pkg::word_t          wram_m [0:32767];
	md_pkg::byte_t          sram_m [0:8191];
	logic [8:0]             bar_m;
	logic                   busreq_m;
	logic                   rst_n_m;
	md_pkg::word_t          ob_m;

	// Expected ROM port write, set around a host ROM write
	logic                   rom_wr_m;
	md_pkg::word_t          rom_wdata_m;
	logic [1:0]             rom_be_m;

	logic [31:0]            rng = 32'd91618;
	int                     n_access = 0;
	int                     cycles = 0;
	int                     fail_count = 0;

	md_bus_top i_dut (
		.MCLK        (MCLK),
		.reset       (reset),
		.main_req    (main_req),
		.main_valid  (main_valid),
		.main_rdata  (main_rdata),
		.main_done   (main_done),
		.sub_req     (sub_req),
		.sub_valid   (sub_valid),
		.sub_rdata   (sub_rdata),
		.sub_done    (sub_done),
		.rom_addr    (rom_addr),
		.rom_req     (rom_req),
		.rom_ack     (rom_ack),
		.rom_data    (rom_data),
		.rom_we      (rom_we),
		.rom_wdata   (rom_wdata),
		.rom_be      (rom_be),
		.busreq      (busreq),
		.z80_reset_n (z80_reset_n)
	);

	always #20 MCLK = ~MCLK;

	function automatic logic [31:0] xorshift();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	// ------------------------------------------------------------------------
	// Reference models
	// ------------------------------------------------------------------------
	function automatic md_pkg::word_t rom_word(input logic [22:0] wa);
		return wa[15:0] ^ 16'hA5A5;
	endfunction

	// Sound bus: RAM at 0000-3FFF with 8 KB mirror, nothing else readable
	function automatic md_pkg::byte_t sram_expect(input logic [14:0] za);
		if (!za[14]) begin
			return sram_m[za[12:0]];
		end
		return 8'hFF;
	endfunction

	function automatic md_pkg::word_t main_expect(input logic [22:0] wa, input logic uds);
		logic [23:0]   ba;
		md_pkg::byte_t b;
		ba = {wa, 1'b0};
		if (ba < 24'hA00000) begin
			return rom_word(wa);
		end
		if (ba < 24'hA10000) begin
			b = (busreq_m && rst_n_m) ? sram_expect({wa[13:0], ~uds}) : 8'hFF;
			return {b, b};
		end
		if (ba == 24'hA11100) begin
			return {ob_m[15:9], ~busreq_m, ob_m[7:0]};
		end
		if (ba == 24'hA11200) begin
			return {ob_m[15:9], ~rst_n_m, ob_m[7:0]};
		end
		if (ba >= 24'hE00000) begin
			return wram_m[wa[14:0]];
		end
		return ob_m;
	endfunction

	function automatic md_pkg::byte_t sub_expect(input logic [15:0] a);
		md_pkg::word_t w;
		if (a[15]) begin
			w = main_expect({bar_m, a[14:1]}, ~a[0]);
			return a[0] ? w[7:0] : w[15:8];
		end
		return sram_expect(a[14:0]);
	endfunction

	task automatic zbus_model_write(input logic [14:0] za, input md_pkg::byte_t d);
		if (!za[14]) begin
			sram_m[za[12:0]] = d;
		end else if (za[14:8] == 7'h60) begin
			bar_m = {d[0], bar_m[8:1]};
		end
	endtask

	task automatic main_model_write(input logic [22:0] wa, input md_pkg::word_t d,
			input logic uds, input logic lds);
		logic [23:0] ba;
		ba = {wa, 1'b0};
		if (ba >= 24'hE00000) begin
			if (uds) begin
				wram_m[wa[14:0]][15:8] = d[15:8];
			end
			if (lds) begin
				wram_m[wa[14:0]][7:0] = d[7:0];
			end
		end else if (ba == 24'hA11100 && uds) begin
			busreq_m = d[8];
		end else if (ba == 24'hA11200 && uds) begin
			rst_n_m = d[8];
		end else if (ba >= 24'hA00000 && ba < 24'hA10000 && busreq_m && rst_n_m) begin
			zbus_model_write({wa[13:0], ~uds}, uds ? d[15:8] : d[7:0]);
		end
	endtask

	// ------------------------------------------------------------------------
	// Failure reporting and compare tasks
	// ------------------------------------------------------------------------
	task automatic stop_with_failure(input string reason);
		fail_count++;
		$display("%s", reason);
		$display("RESULT: FAIL");
		$fatal(1, "Simulation stopped on error");
	endtask

	task automatic check_word(input md_pkg::word_t got, input md_pkg::word_t exp,
			input string what);
		if (got !== exp) begin
			stop_with_failure($sformatf("FAIL at %0t ns: %s, got %h, expected %h",
				$time, what, got, exp));
		end
	endtask

	task automatic check_byte(input md_pkg::byte_t got, input md_pkg::byte_t exp,
			input string what);
		if (got !== exp) begin
			stop_with_failure($sformatf("FAIL at %0t ns: %s, got %h, expected %h",
				$time, what, got, exp));
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			stop_with_failure($sformatf("FAIL at %0t ns: %s, got %b, expected %b",
				$time, what, got, exp));
		end
	endtask

	// ------------------------------------------------------------------------
	// Port access tasks, inputs change on the falling edge
	// ------------------------------------------------------------------------
	task automatic main_access(input md_pkg::main_req_t req, output md_pkg::word_t rdata);
		@(negedge MCLK);
		main_req   = req;
		main_valid = 1'b1;
		n_access++;
		@(negedge MCLK);
		while (main_done !== 1'b1) begin
			@(negedge MCLK);
		end
		rdata      = main_rdata;
		main_valid = 1'b0;
		@(negedge MCLK);
		while (main_done !== 1'b0) begin
			@(negedge MCLK);
		end
	endtask

	// Request stays on the port until done falls, the top muxes done by address
	task automatic sub_access(input md_pkg::sub_req_t req, output md_pkg::byte_t rdata);
		@(negedge MCLK);
		sub_req   = req;
		sub_valid = 1'b1;
		n_access++;
		@(negedge MCLK);
		while (sub_done !== 1'b1) begin
			@(negedge MCLK);
		end
		rdata     = sub_rdata;
		sub_valid = 1'b0;
		@(negedge MCLK);
		while (sub_done !== 1'b0) begin
			@(negedge MCLK);
		end
	endtask

	task automatic host_write(input logic [23:0] ba, input md_pkg::word_t d,
			input logic uds, input logic lds);
		md_pkg::main_req_t req;
		md_pkg::word_t     got;
		req = '{addr: ba[23:1], wdata: d, rnw: 1'b0, uds: uds, lds: lds};
		main_access(req, got);
		main_model_write(ba[23:1], d, uds, lds);
		check_bit(busreq, busreq_m, "busreq output");
		check_bit(z80_reset_n, rst_n_m, "sound CPU reset output");
	endtask

	task automatic host_read(input logic [23:0] ba, input logic uds, input logic lds);
		md_pkg::main_req_t req;
		md_pkg::word_t     exp;
		md_pkg::word_t     got;
		req = '{addr: ba[23:1], wdata: 16'h0000, rnw: 1'b1, uds: uds, lds: lds};
		exp = main_expect(ba[23:1], uds);
		main_access(req, got);
		check_word(got, exp, $sformatf("host read %h", ba));
		// Only RAM and ROM reads reload the open bus
		if (ba < 24'hA00000 || ba >= 24'hE00000) begin
			ob_m = exp;
		end
	endtask

	task automatic sub_write(input logic [15:0] a, input md_pkg::byte_t d);
		md_pkg::sub_req_t req;
		md_pkg::byte_t    got;
		req = '{addr: a, wdata: d, rnw: 1'b0};
		sub_access(req, got);
		if (a[15]) begin
			main_model_write({bar_m, a[14:1]}, {d, d}, ~a[0], a[0]);
		end else begin
			zbus_model_write(a[14:0], d);
		end
	endtask

	task automatic sub_read(input logic [15:0] a);
		md_pkg::sub_req_t req;
		md_pkg::byte_t    exp;
		md_pkg::byte_t    got;
		req = '{addr: a, wdata: 8'h00, rnw: 1'b1};
		exp = sub_expect(a);
		sub_access(req, got);
		check_byte(got, exp, $sformatf("sound CPU read %h", a));
	endtask

	// Random mirror of a work RAM word, byte address
	function automatic logic [23:0] wram_addr_of(input logic [14:0] w);
		logic [31:0] r;
		r = xorshift();
		return {3'b111, r[4:0], w, 1'b0};
	endfunction

	// Nine serial writes, first bit ends up in bar bit 0
	task automatic load_bar(input logic [8:0] value);
		logic [31:0] r;
		for (int k = 0; k < 9; k++) begin
			r = xorshift();
			sub_write({8'h60, r[15:8]}, {r[7:1], value[k]});
		end
	endtask

	// ROM responder, ack follows the toggle after 1 to 6 cycles
	initial begin
		forever begin
			@(negedge MCLK);
			if (reset === 1'b0 && rom_req !== rom_ack) begin
				check_bit(rom_we, rom_wr_m, "ROM write strobe");
				if (rom_wr_m) begin
					check_word(rom_wdata, rom_wdata_m, "ROM write data");
					check_bit(rom_be[1], rom_be_m[1], "ROM upper lane enable");
					check_bit(rom_be[0], rom_be_m[0], "ROM lower lane enable");
				end
				repeat (1 + xorshift() % 6) @(negedge MCLK);
				rom_data = rom_word(rom_addr);
				rom_ack  = rom_req;
			end
		end
	end

	// Watchdog, 400 cycles per access issued
	always @(posedge MCLK) begin
		cycles++;
		if (cycles > 400 * (n_access + 1)) begin
			stop_with_failure($sformatf("Timeout: the DUT did not finish an access after %0d cycles",
				cycles));
		end
	end

	// ------------------------------------------------------------------------
	// Test sequence
	// ------------------------------------------------------------------------
	initial begin
		logic [14:0] wlist [0:15];
		logic [12:0] slist [0:11];
		logic [15:0] zlist [0:7];
		logic [31:0] r;
		logic [22:0] wa;

		reset       = 1'b1;
		main_req    = '0;
		main_valid  = 1'b0;
		sub_req     = '0;
		sub_valid   = 1'b0;
		rom_ack     = 1'b0;
		rom_data    = '0;
		bar_m       = '0;
		busreq_m    = 1'b0;
		rst_n_m     = 1'b0;
		ob_m        = `MD_OPEN_BUS_INIT;
		rom_wr_m    = 1'b0;
		rom_wdata_m = '0;
		rom_be_m    = 2'b00;
		repeat (5) @(posedge MCLK);
		@(negedge MCLK);
		reset = 1'b0;

		// Port levels straight out of reset
		check_bit(rom_req, 1'b0, "ROM request after reset");
		check_bit(rom_we, 1'b0, "ROM write strobe after reset");
		check_bit(busreq, busreq_m, "busreq after reset");
		check_bit(z80_reset_n, rst_n_m, "sound CPU reset after reset");

		// Reset values seen through open bus and control reads
		host_read(24'hC01234, 1'b1, 1'b1);
		host_read(24'hA11100, 1'b1, 1'b1);
		host_read(24'hA11200, 1'b1, 1'b1);

		// Work RAM words, then random lane writes, read back through mirrors
		for (int i = 0; i < 16; i++) begin
			r        = xorshift();
			wlist[i] = r[14:0];
			host_write(wram_addr_of(wlist[i]), r[31:16], 1'b1, 1'b1);
		end
		for (int i = 0; i < 16; i++) begin
			r = xorshift();
			host_write(wram_addr_of(wlist[r[3:0]]), r[31:16], r[4], r[5]);
		end
		for (int i = 0; i < 16; i++) begin
			host_read(wram_addr_of(wlist[i]), 1'b1, 1'b1);
		end

		// ROM pattern, then the same word from an unmapped read
		for (int i = 0; i < 12; i++) begin
			r  = xorshift() % 32'h500000;
			wa = r[22:0];
			host_read({wa, 1'b0}, 1'b1, 1'b1);
			r = xorshift();
			host_read({3'b110, r[19:0], 1'b0}, 1'b1, 1'b1);
		end

		// Host write onto the ROM port, upper lane only
		rom_wdata_m = 16'hC35A;
		rom_be_m    = 2'b10;
		rom_wr_m    = 1'b1;
		host_write(24'h012344, rom_wdata_m, 1'b1, 1'b0);
		rom_wr_m    = 1'b0;

		// Sound window gated until busreq and reset release
		sub_write(16'h0100, 8'h3C);
		host_write(24'hA00100, 16'h9900, 1'b1, 1'b0);
		host_read(24'hA00100, 1'b1, 1'b0);
		sub_read(16'h0100);
		host_write(24'hA11100, 16'h0100, 1'b1, 1'b1);
		host_write(24'hA11200, 16'h0100, 1'b1, 1'b1);
		host_read(24'hA11100, 1'b1, 1'b1);
		host_read(24'hA11200, 1'b1, 1'b1);
		host_write(24'hA00100, 16'h5A00, 1'b1, 1'b0);
		host_write(24'hA00101, 16'h00C3, 1'b0, 1'b1);
		host_read(24'hA00100, 1'b1, 1'b0);
		host_read(24'hA00101, 1'b0, 1'b1);
		sub_read(16'h0101);

		// Sound RAM from the sound CPU, mirror at 2000
		for (int i = 0; i < 12; i++) begin
			r        = xorshift();
			slist[i] = r[12:0];
			sub_write({3'b000, slist[i]}, r[23:16]);
		end
		for (int i = 0; i < 12; i++) begin
			sub_read({3'b001, slist[i]});
			sub_read({3'b000, slist[i]});
		end
		sub_read(16'h4000);
		sub_read(16'h5A5A);
		sub_read(16'h6000);
		sub_read(16'h7FFF);

		// Bank into work RAM
		r = xorshift();
		load_bar({3'b111, r[5:0]});
		for (int i = 0; i < 8; i++) begin
			r        = xorshift();
			zlist[i] = {1'b1, r[14:0]};
			sub_write(zlist[i], r[23:16]);
		end
		for (int i = 0; i < 8; i++) begin
			sub_read(zlist[i]);
		end

		// Bank into ROM
		r = xorshift() % 32'h140;
		load_bar(r[8:0]);
		for (int i = 0; i < 8; i++) begin
			r = xorshift();
			sub_read({1'b1, r[14:0]});
		end

		// Both ports raised on the same falling edge
		for (int i = 0; i < 4; i++) begin
			r = xorshift();
			fork
				host_read(wram_addr_of(wlist[r[3:0]]), 1'b1, 1'b1);
				sub_read({1'b1, r[30:16]});
			join
			r = xorshift() % 32'h500000;
			wa = r[22:0];
			fork
				host_read({wa, 1'b0}, 1'b1, 1'b1);
				sub_read({3'b000, slist[i]});
			join
			fork
				host_read(24'hA00100, 1'b1, 1'b0);
				sub_read({3'b001, slist[i + 4]});
			join
			r = xorshift();
			fork
				host_write(wram_addr_of(wlist[r[3:0]]), r[31:16], 1'b1, 1'b1);
				sub_read({1'b1, r[14:0]});
			join
		end

		repeat (2) @(negedge MCLK);
		if (fail_count == 0) begin
			$display("RESULT: PASS");
			$finish;
		end else begin
			stop_with_failure("One or more checks did not match the reference model");
		end
	end

endmodule

//--- sources.f
+incdir+design
design/md_pkg.sv
design/sync_ram.sv
design/main_bus_arbiter.sv
design/sound_bus_arbiter.sv
design/md_bus_top.sv
tests/tb_md_bus.sv
